/* core.f */
hw/riscv_pkg.sv
hw/pipe_pkg.sv
hw/fetch_unit.sv
hw/instr_queue.sv
hw/decode_stage.sv
hw/register_file.sv
hw/execute_stage.sv
hw/core_top.sv
+incdir+dv
dv/core_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	--top-module core_tb -f core.f -o core_sim

./obj_dir/core_sim | tee sim.log

# the pass line decides the result
grep -q "TESTS PASSED" sim.log

/* dv/core_model.svh */
`ifndef CORE_MODEL_SVH
`define CORE_MODEL_SVH

localparam int K_LUI   = 0;
localparam int K_AUIPC = 1;
localparam int K_ADDI  = 2;
localparam int K_ADD   = 3;
localparam int K_LW    = 4;
localparam int K_SW    = 5;
localparam int K_BEQ   = 6;
localparam int K_JAL   = 7;
localparam int K_JBASE = 8; // addi that loads the jalr base
localparam int K_JALR  = 9;
localparam int K_LOOP  = 10;

localparam logic [31:0] SELF_LOOP = 32'h0000_006f; // jal x0, 0

int kinds [PROG_LEN];

// --------------------
function automatic logic [31:0] enc_i(logic [6:0] op, logic [2:0] f3, logic [4:0] rd,
	logic [4:0] rs1, logic [11:0] imm);
	return {imm, rs1, f3, rd, op};
endfunction

function automatic logic [31:0] enc_s(logic [4:0] rs1, logic [4:0] rs2, logic [11:0] imm);
	return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'h23};
endfunction

function automatic logic [31:0] enc_b(logic [4:0] rs1, logic [4:0] rs2, logic [12:0] off);
	return {off[12], off[10:5], rs2, rs1, 3'b000, off[4:1], off[11], 7'h63};
endfunction

function automatic logic [31:0] enc_j(logic [4:0] rd, logic [20:0] off);
	return {off[20], off[10:1], off[11], off[19:12], rd, 7'h6f};
endfunction

// small register pools make dependences frequent
function automatic logic [4:0] pick_reg(int mode);
	return (mode == 1 || mode == 2) ? 5'($urandom % 4) : 5'($urandom % 16);
endfunction

// forward only, never onto a jalr whose base load would be skipped
function automatic int pick_target(int i);
	int t;
	t = i + 1 + int'($urandom % 4);
	if (t > PROG_LEN - 1) t = PROG_LEN - 1;
	while (kinds[t] == K_JALR) t++;
	return t;
endfunction

function automatic void gen_program(int p, int mode);
	int i;
	int r;
	int t;
	int off;
	int c_arith;
	int c_lw;
	int c_sw;
	int c_beq;
	int c_jal;
	logic [4:0] rd;
	logic [4:0] rs1;
	logic [4:0] rs2;
	logic [4:0] rb;
	logic [11:0] imm;
	case (mode)
		0: begin c_arith = 100; c_lw = 100; c_sw = 100; c_beq = 100; c_jal = 100; end
		1: begin c_arith = 60; c_lw = 80; c_sw = 100; c_beq = 100; c_jal = 100; end
		2: begin c_arith = 25; c_lw = 75; c_sw = 100; c_beq = 100; c_jal = 100; end
		3: begin c_arith = 40; c_lw = 40; c_sw = 40; c_beq = 60; c_jal = 80; end
		default: begin c_arith = 40; c_lw = 60; c_sw = 70; c_beq = 80; c_jal = 90; end
	endcase
	i = 0;
	while (i < PROG_LEN - 1) begin
		r = int'($urandom % 100);
		if (r < c_arith) kinds[i] = int'($urandom % 4);
		else if (r < c_lw) kinds[i] = K_LW;
		else if (r < c_sw) kinds[i] = K_SW;
		else if (r < c_beq) kinds[i] = K_BEQ;
		else if (r < c_jal) kinds[i] = K_JAL;
		else if (i < PROG_LEN - 2) begin
			kinds[i] = K_JBASE;
			kinds[i + 1] = K_JALR;
			i++;
		end else kinds[i] = K_ADDI;
		i++;
	end
	kinds[PROG_LEN - 1] = K_LOOP;

	for (i = 0; i < PROG_LEN; i++) begin
		rd = pick_reg(mode);
		rs1 = pick_reg(mode);
		rs2 = pick_reg(mode);
		imm = 12'($urandom);
		if ((kinds[i] == K_LW || kinds[i] == K_SW) && $urandom % 2 == 1) begin
			rs1 = 5'd0; // absolute word addresses past the memory size alias
			imm = 12'(4 * ($urandom % 128));
		end
		case (kinds[i])
			K_LUI:   progs[p][i] = {20'($urandom), rd, 7'h37};
			K_AUIPC: progs[p][i] = {20'($urandom), rd, 7'h17};
			K_ADDI:  progs[p][i] = enc_i(7'h13, 3'b000, rd, rs1, imm);
			K_ADD:   progs[p][i] = {7'b0, rs2, rs1, 3'b000, rd, 7'h33};
			K_LW:    progs[p][i] = enc_i(7'h03, 3'b010, rd, rs1, imm);
			K_SW:    progs[p][i] = enc_s(rs1, rs2, imm);
			K_BEQ: begin
				if ($urandom % 2 == 1) rs2 = rs1;
				t = pick_target(i);
				progs[p][i] = enc_b(rs1, rs2, 13'((t - i) * 4));
			end
			K_JAL: begin
				t = pick_target(i);
				progs[p][i] = enc_j(rd, 21'((t - i) * 4));
			end
			K_JBASE: begin
				t = pick_target(i + 1);
				off = 4 * int'($urandom % 3);
				rb = 5'(1 + $urandom % 15);
				progs[p][i] = enc_i(7'h13, 3'b000, rb, 5'd0, 12'(t * 4 - off));
				progs[p][i + 1] = enc_i(7'h67, 3'b000, rd, rb, 12'(off));
			end
			K_JALR: ; // written together with its base load
			default: progs[p][i] = SELF_LOOP;
		endcase
	end
endfunction

// --------------------
// architectural model, one retire record per executed instruction
function automatic void run_model(int p);
	logic [31:0] x [16];
	logic [31:0] dm [DMEM_WORDS];
	logic [31:0] pc;
	logic [31:0] w;
	logic [31:0] a;
	logic [31:0] b;
	logic [31:0] nxt;
	logic [31:0] imm_i;
	logic [31:0] imm_s;
	logic [31:0] imm_b;
	logic [31:0] imm_j;
	retire_t r;
	foreach (x[k]) x[k] = '0;
	foreach (dm[k]) dm[k] = '0;
	pc = '0;
	for (int step = 0; step < PROG_LEN; step++) begin
		w = progs[p][pc >> 2];
		a = x[w[18:15]];
		b = x[w[23:20]];
		imm_i = {{20{w[31]}}, w[31:20]};
		imm_s = {{20{w[31]}}, w[31:25], w[11:7]};
		imm_b = {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
		imm_j = {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
		r = '0;
		r.pc = pc;
		r.rd = w[10:7];
		nxt = pc + 32'd4;
		case (w[6:0])
			7'h37: begin r.reg_wen = 1'b1; r.wb_value = {w[31:12], 12'b0}; end
			7'h17: begin r.reg_wen = 1'b1; r.wb_value = pc + {w[31:12], 12'b0}; end
			7'h6f: begin r.reg_wen = 1'b1; r.wb_value = pc + 32'd4; nxt = pc + imm_j; end
			7'h67: begin
				r.reg_wen = 1'b1;
				r.wb_value = pc + 32'd4;
				nxt = (a + imm_i) & ~32'd1;
			end
			7'h63: if (a == b) nxt = pc + imm_b;
			7'h03: begin r.reg_wen = 1'b1; r.wb_value = dm[((a + imm_i) >> 2) % DMEM_WORDS]; end
			7'h23: begin
				r.store = 1'b1;
				r.store_addr = a + imm_s;
				r.store_data = b;
				dm[((a + imm_s) >> 2) % DMEM_WORDS] = b;
			end
			7'h13: begin r.reg_wen = 1'b1; r.wb_value = a + imm_i; end
			7'h33: begin r.reg_wen = 1'b1; r.wb_value = w[30] ? a - b : a + b; end
			default: ;
		endcase
		if (!r.reg_wen || r.rd == '0) r.wb_value = '0;
		if (r.reg_wen && r.rd != '0) x[r.rd] = r.wb_value;
		exp_q.push_back(r);
		if (w == SELF_LOOP) return;
		pc = nxt;
	end
endfunction

`endif

/* dv/core_tb.sv */
module core_tb import pipe_pkg::*; ();

	localparam int NUM_PROGS   = 6;
	localparam int PROG_LEN    = 48;
	localparam int QUEUE_DEPTH = 4;
	localparam int DMEM_WORDS  = 64;
	localparam int CYCLE_LIMIT = 40 * NUM_PROGS * PROG_LEN;

	logic        clock;
	logic        reset;
	logic [31:0] imem_addr;
	logic [31:0] imem_data;
	logic        imem_valid;
	logic        retire_valid;
	retire_t     retire;

	logic [31:0] progs [NUM_PROGS][PROG_LEN];
	retire_t     exp_q [$];
	retire_t     exp_rec;
	int          cur;
	int          gap_pct;
	int          cycles;
	bit          running;
	bit          prog_done;

	`include "core_model.svh"

	core_top #(
		.QUEUE_DEPTH(QUEUE_DEPTH),
		.DMEM_WORDS(DMEM_WORDS),
		.RESET_PC(32'h0)
	) UUT (
		.clock(clock),
		.reset(reset),
		.imem_addr(imem_addr),
		.imem_data(imem_data),
		.imem_valid(imem_valid),
		.retire_valid(retire_valid),
		.retire(retire)
	);

	always #10 clock = ~clock;

	task automatic fail_run(string msg);
		$display("%s", msg);
		$display("TESTS FAILED");
		$fatal(1, "simulation stopped");
	endtask

	task automatic check_field(string name, logic [31:0] got, logic [31:0] exp, logic [31:0] pc);
		if (got !== exp) begin
			$display("ERROR at %0t: pc %h field %s is %h, expected %h", $time, pc, name, got, exp);
			fail_run("retired instruction does not match the model");
		end
	endtask

	task automatic check_retire(retire_t got, retire_t exp);
		check_field("pc", got.pc, exp.pc, exp.pc);
		check_field("rd", 32'(got.rd), 32'(exp.rd), exp.pc);
		check_field("reg_wen", 32'(got.reg_wen), 32'(exp.reg_wen), exp.pc);
		check_field("wb_value", got.wb_value, exp.wb_value, exp.pc);
		check_field("store", 32'(got.store), 32'(exp.store), exp.pc);
		check_field("store_addr", got.store_addr, exp.store_addr, exp.pc);
		check_field("store_data", got.store_data, exp.store_data, exp.pc);
	endtask

	// --------------------
	// instruction port, words past the program read as addi x0, x0, 0
	always @(negedge clock) begin
		imem_valid = (int'($urandom % 100) >= gap_pct);
		if ((imem_addr >> 2) < PROG_LEN) imem_data = progs[cur][imem_addr >> 2];
		else imem_data = 32'h0000_0013;
	end

	always @(posedge clock) begin
		cycles++;
		if (cycles > CYCLE_LIMIT) begin
			fail_run("timeout: the programs did not reach their self-loops in time");
		end
	end

	always @(posedge clock) begin
		if (running && retire_valid) begin
			exp_rec = exp_q.pop_front();
			check_retire(retire, exp_rec);
			if (exp_q.size() == 0) begin // the self-loop has retired
				running = 1'b0;
				prog_done = 1'b1;
			end
		end
	end

	// --------------------
	initial begin
		clock = 1'b0;
		reset = 1'b1;
		imem_valid = 1'b0;
		imem_data = '0;
		running = 1'b0;
		prog_done = 1'b0;
		cycles = 0;
		cur = 0;
		gap_pct = 0;
		void'($urandom(32'h18d7_5e90));
		for (int p = 0; p < NUM_PROGS; p++) begin
			@(negedge clock);
			reset = 1'b1;
			gen_program(p, (p < 5) ? p : 4);
			cur = p;
			gap_pct = (p == 2 || p >= 4) ? 40 : 0; // back-pressure phases
			exp_q.delete();
			run_model(p);
			repeat (4) @(negedge clock);
			reset = 1'b0;
			prog_done = 1'b0;
			running = 1'b1;
			wait (prog_done);
		end
		$display("TESTS PASSED");
		$finish;
	end

endmodule

/* hw/core_top.sv */
module core_top import riscv_pkg::*, pipe_pkg::*; #(
	parameter int          QUEUE_DEPTH = 4,
	parameter int          DMEM_WORDS  = 64,
	parameter logic [31:0] RESET_PC    = 32'h0
) (
	input  logic        clock,
	input  logic        reset,
	output logic [31:0] imem_addr,
	input  logic [31:0] imem_data,
	input  logic        imem_valid,
	output logic        retire_valid,
	output retire_t     retire
);

	logic                  push_valid;
	fetch_pkt_t            push_pkt;
	logic                  credit_return;
	redirect_t             redirect;
	logic                  queue_valid;
	fetch_pkt_t            queue_pkt;
	logic                  decode_ready;
	logic [REG_ADDR_W-1:0] rs1;
	logic [REG_ADDR_W-1:0] rs2;
	logic [31:0]           rs1_data;
	logic [31:0]           rs2_data;
	bypass_t               bypass;
	logic                  exu_valid;
	logic                  exu_ready;
	decoded_t              exu_inst;
	logic                  rf_wen;
	logic [REG_ADDR_W-1:0] rf_rd;
	logic [31:0]           rf_wdata;

	fetch_unit #(
		.QUEUE_DEPTH(QUEUE_DEPTH),
		.RESET_PC(RESET_PC)
	) u_fetch (
		.clock(clock),
		.reset(reset),
		.imem_addr(imem_addr),
		.imem_data(imem_data),
		.imem_valid(imem_valid),
		.push_valid(push_valid),
		.push_pkt(push_pkt),
		.credit_return(credit_return),
		.redirect(redirect)
	);

	instr_queue #(
		.QUEUE_DEPTH(QUEUE_DEPTH)
	) u_queue (
		.clock(clock),
		.reset(reset),
		.push_valid(push_valid),
		.push_pkt(push_pkt),
		.credit_return(credit_return),
		.flush(redirect.valid), // squash the wrong path
		.queue_valid(queue_valid),
		.queue_pkt(queue_pkt),
		.decode_ready(decode_ready)
	);

	decode_stage u_decode (
		.clock(clock),
		.reset(reset),
		.queue_valid(queue_valid),
		.queue_pkt(queue_pkt),
		.decode_ready(decode_ready),
		.rs1(rs1),
		.rs2(rs2),
		.rs1_data(rs1_data),
		.rs2_data(rs2_data),
		.bypass(bypass),
		.flush(redirect.valid),
		.exu_valid(exu_valid),
		.exu_ready(exu_ready),
		.exu_inst(exu_inst)
	);

	register_file u_regs (
		.clock(clock),
		.reset(reset),
		.rs1(rs1),
		.rs2(rs2),
		.rs1_data(rs1_data),
		.rs2_data(rs2_data),
		.wen(rf_wen),
		.rd(rf_rd),
		.wdata(rf_wdata)
	);

	execute_stage #(
		.DMEM_WORDS(DMEM_WORDS)
	) u_execute (
		.clock(clock),
		.reset(reset),
		.exu_valid(exu_valid),
		.exu_ready(exu_ready),
		.exu_inst(exu_inst),
		.bypass(bypass),
		.redirect(redirect),
		.rf_wen(rf_wen),
		.rf_rd(rf_rd),
		.rf_wdata(rf_wdata),
		.retire_valid(retire_valid),
		.retire(retire)
	);

endmodule

/* hw/execute_stage.sv */
module execute_stage import riscv_pkg::*, pipe_pkg::*; #(
	parameter int DMEM_WORDS = 64
) (
	input  logic                  clock,
	input  logic                  reset,
	input  logic                  exu_valid,
	output logic                  exu_ready,
	input  decoded_t              exu_inst,
	output bypass_t               bypass,
	output redirect_t             redirect,
	output logic                  rf_wen,
	output logic [REG_ADDR_W-1:0] rf_rd,
	output logic [31:0]           rf_wdata,
	output logic                  retire_valid,
	output retire_t               retire
);

	localparam int IDX_W = $clog2(DMEM_WORDS);

	logic [31:0]           dmem [DMEM_WORDS];
	logic                  take;
	logic                  is_load;
	logic                  is_store;
	logic [31:0]           sum_ai;
	logic [31:0]           result;
	logic [IDX_W-1:0]      mem_idx;
	logic                  ld_pending;
	logic [31:0]           ld_pc;
	logic [REG_ADDR_W-1:0] ld_rd;
	logic [31:0]           ld_data;

	// the writeback cycle of a load owns the write port and the retire port
	assign exu_ready = ~ld_pending;
	assign take      = exu_valid & exu_ready;
	assign is_load   = (exu_inst.opclass == OC_LW);
	assign is_store  = (exu_inst.opclass == OC_SW);
	assign sum_ai    = exu_inst.op_a + exu_inst.imm;
	assign mem_idx   = sum_ai[2 +: IDX_W]; // word index, wraps over the memory

	always_comb begin
		case (exu_inst.opclass)
			OC_LUI:          result = exu_inst.imm;
			OC_AUIPC:        result = exu_inst.pc + exu_inst.imm;
			OC_JAL, OC_JALR: result = exu_inst.pc + 32'd4;
			OC_ADDI:         result = sum_ai;
			OC_ADD:          result = exu_inst.funct7_5 ? exu_inst.op_a - exu_inst.op_b
				: exu_inst.op_a + exu_inst.op_b;
			default:         result = '0;
		endcase
	end

	// --------------------
	always_comb begin
		redirect.valid  = 1'b0;
		redirect.target = exu_inst.pc + exu_inst.imm;
		if (take) begin
			case (exu_inst.opclass)
				OC_JAL:  redirect.valid = 1'b1;
				OC_JALR: begin
					redirect.valid  = 1'b1;
					redirect.target = {sum_ai[31:1], 1'b0};
				end
				OC_BEQ:  redirect.valid = (exu_inst.funct3 == 3'b000) &&
					(exu_inst.op_a == exu_inst.op_b);
				default: redirect.valid = 1'b0;
			endcase
		end
	end

	always_comb begin
		retire = '0;
		if (ld_pending) begin
			retire.pc       = ld_pc;
			retire.rd       = ld_rd;
			retire.reg_wen  = 1'b1;
			retire.wb_value = ld_data;
		end else begin
			retire.pc       = exu_inst.pc;
			retire.rd       = exu_inst.rd;
			retire.reg_wen  = exu_inst.reg_wen;
			retire.wb_value = result;
			if (is_store) begin
				retire.store      = 1'b1;
				retire.store_addr = sum_ai;
				retire.store_data = exu_inst.op_b;
			end
		end
		if (!retire.reg_wen || retire.rd == '0) begin
			retire.wb_value = '0;
		end
	end

	assign retire_valid = ld_pending | (take & ~is_load);
	assign rf_wen       = retire_valid & retire.reg_wen & (retire.rd != '0);
	assign rf_rd        = retire.rd;
	assign rf_wdata     = retire.wb_value;

	assign bypass.busy     = ld_pending;
	assign bypass.wb_valid = ld_pending; // data is already registered when pending
	assign bypass.rd       = ld_rd;
	assign bypass.reg_wen  = 1'b1;
	assign bypass.wb_value = ld_data;

	// --------------------
	always_ff @(posedge clock) begin
		if (reset) begin
			ld_pending <= 1'b0;
		end else begin
			ld_pending <= take & is_load;
		end
	end

	always_ff @(posedge clock) begin
		if (take & is_load) begin
			ld_pc   <= exu_inst.pc;
			ld_rd   <= exu_inst.rd;
			ld_data <= dmem[mem_idx];
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			for (int i = 0; i < DMEM_WORDS; i++) begin
				dmem[i] <= '0;
			end
		end else if (take & is_store) begin
			dmem[mem_idx] <= exu_inst.op_b;
		end
	end

	// fetch and the queue only ever see word addresses
	a_target_aligned: assert property (
		@(posedge clock) disable iff (reset)
		redirect.valid |-> (redirect.target[1:0] == 2'b00)
	);
	a_retire_aligned: assert property (
		@(posedge clock) disable iff (reset)
		retire_valid |-> (retire.pc[1:0] == 2'b00)
	);

endmodule

/* hw/register_file.sv */
module register_file import riscv_pkg::*; (
	input  logic                  clock,
	input  logic                  reset,
	input  logic [REG_ADDR_W-1:0] rs1,
	input  logic [REG_ADDR_W-1:0] rs2,
	output logic [31:0]           rs1_data,
	output logic [31:0]           rs2_data,
	input  logic                  wen,
	input  logic [REG_ADDR_W-1:0] rd,
	input  logic [31:0]           wdata
);

	localparam int NUM_REGS = 2 ** REG_ADDR_W;

	logic [31:0] regs [NUM_REGS];

	assign rs1_data = (rs1 == '0) ? 32'h0 : regs[rs1];
	assign rs2_data = (rs2 == '0) ? 32'h0 : regs[rs2];

	always_ff @(posedge clock) begin
		if (reset) begin
			for (int i = 0; i < NUM_REGS; i++) begin
				regs[i] <= '0;
			end
		end else if (wen && rd != '0) begin
			regs[rd] <= wdata;
		end
	end

endmodule

/* hw/decode_stage.sv */
module decode_stage import riscv_pkg::*, pipe_pkg::*; (
	input  logic                  clock,
	input  logic                  reset,
	input  logic                  queue_valid,
	input  fetch_pkt_t            queue_pkt,
	output logic                  decode_ready,
	output logic [REG_ADDR_W-1:0] rs1,
	output logic [REG_ADDR_W-1:0] rs2,
	input  logic [31:0]           rs1_data,
	input  logic [31:0]           rs2_data,
	input  bypass_t               bypass,
	input  logic                  flush,
	output logic                  exu_valid,
	input  logic                  exu_ready,
	output decoded_t              exu_inst
);

	logic [31:0]           instr;
	logic [4:0]            opcode_5;
	logic [REG_ADDR_W-1:0] rd;
	opclass_e              opclass;
	fmt_e                  fmt;
	logic [31:0]           imm;
	logic                  need_rs1;
	logic                  need_rs2;
	logic                  reg_wen;
	logic                  exu_match;
	logic                  own_match;
	logic                  rs1_exu_hit;
	logic                  rs2_exu_hit;
	logic                  rs1_own_hit;
	logic                  rs2_own_hit;
	logic                  hazard;
	logic                  accept;

	// --------------------
	// fields, upper bit of each register field is dropped for RV32E
	assign instr    = queue_pkt.instr;
	assign opcode_5 = instr[6:2];
	assign rs1      = instr[15 +: REG_ADDR_W];
	assign rs2      = instr[20 +: REG_ADDR_W];
	assign rd       = instr[7 +: REG_ADDR_W];

	always_comb begin
		case (opcode_5)
			OPC_LUI:    opclass = OC_LUI;
			OPC_AUIPC:  opclass = OC_AUIPC;
			OPC_JAL:    opclass = OC_JAL;
			OPC_JALR:   opclass = OC_JALR;
			OPC_BRANCH: opclass = OC_BEQ;
			OPC_LOAD:   opclass = OC_LW;
			OPC_STORE:  opclass = OC_SW;
			OPC_IMM:    opclass = OC_ADDI;
			OPC_REG:    opclass = OC_ADD;
			default:    opclass = OC_NONE;
		endcase
	end

	always_comb begin
		case (opclass)
			OC_LUI, OC_AUIPC:       fmt = FMT_U;
			OC_JAL:                 fmt = FMT_J;
			OC_JALR, OC_LW, OC_ADDI: fmt = FMT_I;
			OC_BEQ:                 fmt = FMT_B;
			OC_SW:                  fmt = FMT_S;
			default:                fmt = FMT_R;
		endcase
	end

	always_comb begin
		case (fmt)
			FMT_I:   imm = {{20{instr[31]}}, instr[31:20]};
			FMT_S:   imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
			FMT_B:   imm = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
			FMT_U:   imm = {instr[31:12], 12'b0};
			FMT_J:   imm = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};
			default: imm = '0;
		endcase
	end

	assign need_rs2 = opclass inside {OC_BEQ, OC_SW, OC_ADD};
	assign need_rs1 = need_rs2 | (opclass inside {OC_JALR, OC_LW, OC_ADDI});
	assign reg_wen  = opclass inside {OC_LUI, OC_AUIPC, OC_JAL, OC_JALR, OC_LW, OC_ADDI, OC_ADD};

	// --------------------
	// read-after-write against execute and against our own output register
	assign exu_match = bypass.busy & bypass.reg_wen & (bypass.rd != '0);
	assign own_match = exu_valid & exu_inst.reg_wen & (exu_inst.rd != '0);

	assign rs1_exu_hit = need_rs1 & exu_match & (bypass.rd == rs1);
	assign rs2_exu_hit = need_rs2 & exu_match & (bypass.rd == rs2);
	assign rs1_own_hit = need_rs1 & own_match & (exu_inst.rd == rs1);
	assign rs2_own_hit = need_rs2 & own_match & (exu_inst.rd == rs2);

	assign hazard = rs1_own_hit | rs2_own_hit |
		(~bypass.wb_valid & (rs1_exu_hit | rs2_exu_hit));

	assign decode_ready = ~hazard & (~exu_valid | exu_ready);
	assign accept       = queue_valid & decode_ready;

	always_ff @(posedge clock) begin
		if (reset) begin
			exu_valid <= 1'b0;
		end else begin
			exu_valid <= (accept | (exu_valid & ~exu_ready)) & ~flush;
		end
	end

	always_ff @(posedge clock) begin
		if (accept) begin
			exu_inst.pc       <= queue_pkt.pc;
			exu_inst.opclass  <= opclass;
			exu_inst.funct3   <= instr[14:12];
			exu_inst.funct7_5 <= instr[30];
			exu_inst.rd       <= rd;
			exu_inst.reg_wen  <= reg_wen;
			exu_inst.op_a     <= rs1_exu_hit ? bypass.wb_value : rs1_data;
			exu_inst.op_b     <= rs2_exu_hit ? bypass.wb_value : rs2_data;
			exu_inst.imm      <= imm;
		end
	end

endmodule

/* hw/instr_queue.sv */
module instr_queue import pipe_pkg::*; #(
	parameter int QUEUE_DEPTH = 4
) (
	input  logic       clock,
	input  logic       reset,
	input  logic       push_valid,
	input  fetch_pkt_t push_pkt,
	output logic       credit_return,
	input  logic       flush,
	output logic       queue_valid,
	output fetch_pkt_t queue_pkt,
	input  logic       decode_ready
);

	localparam int PTR_W = $clog2(QUEUE_DEPTH);
	localparam int CNT_W = $clog2(QUEUE_DEPTH + 1);

	fetch_pkt_t       slots [QUEUE_DEPTH];
	logic [PTR_W-1:0] rd_ptr;
	logic [PTR_W-1:0] wr_ptr;
	logic [CNT_W-1:0] count;
	logic             pop;

	assign queue_valid = (count != '0);
	assign queue_pkt   = slots[rd_ptr];
	assign pop         = queue_valid & decode_ready;

	// fetch refills its own credits on a flush
	assign credit_return = pop & ~flush;

	// --------------------
	// pointers wrap on their own since the depth is a power of two
	always_ff @(posedge clock) begin
		if (reset | flush) begin
			rd_ptr <= '0;
			wr_ptr <= '0;
			count  <= '0;
		end else begin
			if (push_valid) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (pop) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			count <= count + CNT_W'(push_valid) - CNT_W'(pop);
		end
	end

	always_ff @(posedge clock) begin
		if (push_valid) begin
			slots[wr_ptr] <= push_pkt;
		end
	end

	// --------------------
	// fetch only pushes against a credit so a full queue never sees a push
	a_no_push_when_full: assert property (
		@(posedge clock) disable iff (reset)
		push_valid |-> (count != CNT_W'(QUEUE_DEPTH))
	);

endmodule

/* hw/fetch_unit.sv */
module fetch_unit import pipe_pkg::*; #(
	parameter int          QUEUE_DEPTH = 4,
	parameter logic [31:0] RESET_PC    = 32'h0
) (
	input  logic        clock,
	input  logic        reset,
	output logic [31:0] imem_addr,
	input  logic [31:0] imem_data,
	input  logic        imem_valid,
	output logic        push_valid,
	output fetch_pkt_t  push_pkt,
	input  logic        credit_return,
	input  redirect_t   redirect
);

	localparam int CREDIT_W = $clog2(QUEUE_DEPTH + 1);
	localparam logic [CREDIT_W-1:0] FULL_CREDITS = CREDIT_W'(QUEUE_DEPTH);

	logic [31:0]         pc;
	logic [CREDIT_W-1:0] credits;

	assign imem_addr = pc;

	// the word on the port is from the squashed path while a redirect is out
	assign push_valid = imem_valid & (credits != '0) & ~redirect.valid;

	assign push_pkt.pc    = pc;
	assign push_pkt.instr = imem_data;

	always_ff @(posedge clock) begin
		if (reset) begin
			pc      <= RESET_PC;
			credits <= FULL_CREDITS;
		end else if (redirect.valid) begin
			pc      <= redirect.target;
			credits <= FULL_CREDITS; // queue is flushed in the same cycle
		end else begin
			if (push_valid) begin
				pc <= pc + 32'd4; // branches predicted not taken
			end
			credits <= credits - CREDIT_W'(push_valid) + CREDIT_W'(credit_return);
		end
	end

	// returned credits must match pushes, else the queue could overflow
	a_credit_bound: assert property (
		@(posedge clock) disable iff (reset)
		credits <= FULL_CREDITS
	);

endmodule

/* hw/pipe_pkg.sv */
package pipe_pkg;
	import riscv_pkg::*;

	typedef struct packed {
		logic [31:0] pc;
		logic [31:0] instr;
	} fetch_pkt_t;

	typedef struct packed {
		logic        valid;
		logic [31:0] target;
	} redirect_t;

	// what execute still owes the register file
	typedef struct packed {
		logic                  busy;
		logic                  wb_valid;
		logic [REG_ADDR_W-1:0] rd;
		logic                  reg_wen;
		logic [31:0]           wb_value;
	} bypass_t;

	typedef struct packed {
		logic [31:0]           pc;
		logic [REG_ADDR_W-1:0] rd;
		logic                  reg_wen;
		logic [31:0]           wb_value; // zero unless a nonzero register is written
		logic                  store;
		logic [31:0]           store_addr;
		logic [31:0]           store_data;
	} retire_t;

endpackage

/* hw/riscv_pkg.sv */
package riscv_pkg;

	localparam int REG_ADDR_W = 4; // RV32E has sixteen registers

	// --------------------
	// major opcodes, taken from instr[6:2]
	localparam logic [4:0] OPC_LUI   = 5'b01101;
	localparam logic [4:0] OPC_AUIPC = 5'b00101;
	localparam logic [4:0] OPC_JAL   = 5'b11011;
	localparam logic [4:0] OPC_JALR  = 5'b11001;
	localparam logic [4:0] OPC_BRANCH = 5'b11000;
	localparam logic [4:0] OPC_LOAD  = 5'b00000;
	localparam logic [4:0] OPC_STORE = 5'b01000;
	localparam logic [4:0] OPC_IMM   = 5'b00100;
	localparam logic [4:0] OPC_REG   = 5'b01100;

	// one bit per recognised class
	typedef enum logic [9:0] {
		OC_LUI   = 10'b00_0000_0001,
		OC_AUIPC = 10'b00_0000_0010,
		OC_JAL   = 10'b00_0000_0100,
		OC_JALR  = 10'b00_0000_1000,
		OC_BEQ   = 10'b00_0001_0000,
		OC_LW    = 10'b00_0010_0000,
		OC_SW    = 10'b00_0100_0000,
		OC_ADDI  = 10'b00_1000_0000,
		OC_ADD   = 10'b01_0000_0000,
		OC_NONE  = 10'b10_0000_0000 // anything else retires as a no-op
	} opclass_e;

	typedef enum logic [2:0] {
		FMT_R,
		FMT_I,
		FMT_S,
		FMT_B,
		FMT_U,
		FMT_J
	} fmt_e;

	// --------------------
	typedef struct packed {
		logic [31:0]           pc;
		opclass_e              opclass;
		logic [2:0]            funct3;
		logic                  funct7_5;
		logic [REG_ADDR_W-1:0] rd;
		logic                  reg_wen;
		logic [31:0]           op_a; // rs1 value after forwarding
		logic [31:0]           op_b; // rs2 value after forwarding
		logic [31:0]           imm;
	} decoded_t;

endpackage
